//--- hdl/viu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Widths, tag beat layout and FSM states of the VLAN isolation unit
// Route id zero is reserved and means no route
////////////////////////////////////////////////////////////////////////////
package viu_pkg;

    // Widths that carry a meaning
    localparam int NET_DATA_BITS = 64;
    localparam int ROUTE_ID_BITS = 14;
    localparam int NODE_ID_BITS  = 4;
    localparam int TPID_BITS     = 16;

    // One stream beat
    typedef logic [NET_DATA_BITS-1:0] net_data_t;

    // Route id: [9:6] sender, [5:2] receiver, [1:0] flags, upper bits unused
    typedef logic [ROUTE_ID_BITS-1:0] route_id_t;

    // Sender or receiver id
    typedef logic [NODE_ID_BITS-1:0] node_id_t;

    // 802.1Q tag protocol id
    localparam logic [TPID_BITS-1:0] VLAN_TPID = 16'h8100;

    // Tag beat layout, all other bits zero
    localparam int TAG_TPID_LSB  = 48;
    localparam int TAG_ROUTE_LSB = 32;

    // Receiver id position inside a route id
    localparam int TAG_RECV_LSB  = 2;

    // Transmit side tagger
    typedef enum logic {
        TAG,
        BODY
    } tag_ins_state_t;

    // Receive side untagger
    typedef enum logic [1:0] {
        HEAD,
        PASS,
        DROP
    } tag_ext_state_t;

endpackage

//--- hdl/route_id_select.sv
////////////////////////////////////////////////////////////////////////////
// Strobes are single-cycle pulses without back-pressure
// A held id of zero is skipped, RDMA wins over TCP over the external id
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module route_id_select import viu_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,

    // RDMA connection table lookup
    input  route_id_t rdma_route_id,
    input  logic      rdma_route_id_valid,

    // TCP connection table lookup
    input  route_id_t tcp_route_id,
    input  logic      tcp_route_id_valid,

    // Fallback from the switch
    input  route_id_t ext_route_id,

    output route_id_t tx_route
);

    route_id_t rdma_held;
    route_id_t tcp_held;

    // The id is known when the command is processed,
    // the packet itself shows up later
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rdma_held <= '0;
        end else if (rdma_route_id_valid) begin
            rdma_held <= rdma_route_id;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            tcp_held <= '0;
        end else if (tcp_route_id_valid) begin
            tcp_held <= tcp_route_id;
        end
    end

    // Priority choice
    always_comb begin
        if (rdma_held != '0) begin
            tx_route = rdma_held;
        end else if (tcp_held != '0) begin
            tx_route = tcp_held;
        end else begin
            tx_route = ext_route_id;
        end
    end

endmodule

//--- hdl/vlan_tag_insert.sv
////////////////////////////////////////////////////////////////////////////
// Adds no latency and offers the tag beat once a first beat waits
// Tag route is sampled in the cycle the tag beat is accepted
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module vlan_tag_insert import viu_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,

    input  route_id_t tx_route,

    // Untagged packets from the stack
    input  net_data_t s_tdata,
    input  logic      s_tlast,
    input  logic      s_tvalid,
    output logic      s_tready,

    // Tagged packets toward the MAC
    output net_data_t m_tdata,
    output logic      m_tlast,
    output logic      m_tvalid,
    input  logic      m_tready
);

    tag_ins_state_t state;
    net_data_t      tag_beat;

    // TPID on top, route below it, rest zero
    always_comb begin
        tag_beat = '0;
        tag_beat[TAG_TPID_LSB +: TPID_BITS] = VLAN_TPID;
        tag_beat[TAG_ROUTE_LSB +: ROUTE_ID_BITS] = tx_route;
    end

    always_comb begin
        // Valid follows the input in both states
        m_tvalid = s_tvalid;
        if (state == TAG) begin
            // Hold the first body beat back while the tag goes out
            s_tready = 1'b0;
            m_tdata  = tag_beat;
            m_tlast  = 1'b0;
        end else begin
            s_tready = m_tready;
            m_tdata  = s_tdata;
            m_tlast  = s_tlast;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= TAG;
        end else begin
            case (state)
                TAG: begin
                    if (m_tvalid && m_tready) begin
                        state <= BODY;
                    end
                end
                BODY: begin
                    // Next packet gets its own tag
                    if (s_tvalid && s_tready && s_tlast) begin
                        state <= TAG;
                    end
                end
                default: begin
                    state <= TAG;
                end
            endcase
        end
    end

endmodule

//--- hdl/vlan_tag_extract.sv
////////////////////////////////////////////////////////////////////////////
// First beat of every packet must be the tag, it is never forwarded
// Rejected packets are consumed at full rate regardless of output ready
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module vlan_tag_extract import viu_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,

    // Routing capability, only the receiver field is checked
    input  route_id_t vlan_ctrl,

    // Tagged packets from the MAC
    input  net_data_t s_tdata,
    input  logic      s_tlast,
    input  logic      s_tvalid,
    output logic      s_tready,

    // Untagged packets toward the stack
    output net_data_t m_tdata,
    output logic      m_tlast,
    output logic      m_tvalid,
    input  logic      m_tready,
    output route_id_t m_route
);

    tag_ext_state_t state;
    route_id_t      tag_route;
    route_id_t      route_q;
    node_id_t       tag_recv;
    node_id_t       ctrl_recv;
    logic           tag_ok;
    logic           s_fire;

    // Tag fields of the current input beat
    assign tag_route = s_tdata[TAG_ROUTE_LSB +: ROUTE_ID_BITS];
    assign tag_recv  = tag_route[TAG_RECV_LSB +: NODE_ID_BITS];
    assign ctrl_recv = vlan_ctrl[TAG_RECV_LSB +: NODE_ID_BITS];
    assign tag_ok    = (s_tdata[TAG_TPID_LSB +: TPID_BITS] == VLAN_TPID) &&
                       (tag_recv == ctrl_recv);

    assign s_fire = s_tvalid && s_tready;

    // Body beats pass as they are
    assign m_tdata = s_tdata;
    assign m_tlast = s_tlast;
    assign m_route = route_q;

    always_comb begin
        case (state)
            PASS: begin
                s_tready = m_tready;
                m_tvalid = s_tvalid;
            end
            default: begin
                // Tag and dropped beats are swallowed
                s_tready = 1'b1;
                m_tvalid = 1'b0;
            end
        endcase
    end

    // Route stays with the packet until its last beat
    always_ff @(posedge aclk) begin
        if (state == HEAD && s_fire) begin
            route_q <= tag_route;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= HEAD;
        end else if (s_fire) begin
            case (state)
                HEAD: begin
                    // A lone tag beat carries no body
                    if (s_tlast) begin
                        state <= HEAD;
                    end else if (tag_ok) begin
                        state <= PASS;
                    end else begin
                        state <= DROP;
                    end
                end
                PASS, DROP: begin
                    if (s_tlast) begin
                        state <= HEAD;
                    end
                end
                default: begin
                    state <= HEAD;
                end
            endcase
        end
    end

endmodule

//--- hdl/net_slice_array.sv
////////////////////////////////////////////////////////////////////////////
// N_STAGES of at least 1, ready is combinational through the whole chain
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module net_slice_array #(
    parameter int unsigned N_STAGES = 2,
    parameter int unsigned W        = 65
) (
    input  logic         aclk,
    input  logic         aresetn,

    input  logic [W-1:0] s_payload,
    input  logic         s_tvalid,
    output logic         s_tready,

    output logic [W-1:0] m_payload,
    output logic         m_tvalid,
    input  logic         m_tready
);

    // Index 0 is the input, index N_STAGES the output
    logic [N_STAGES:0] vld;
    logic [N_STAGES:0] rdy;
    logic [W-1:0]      dat [N_STAGES+1];

    assign vld[0]   = s_tvalid;
    assign dat[0]   = s_payload;
    assign s_tready = rdy[0];

    assign m_tvalid      = vld[N_STAGES];
    assign m_payload     = dat[N_STAGES];
    assign rdy[N_STAGES] = m_tready;

    for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
        // Take a beat when empty or when the held one leaves now
        assign rdy[i] = !vld[i+1] || rdy[i+1];

        always_ff @(posedge aclk) begin
            if (!aresetn) begin
                vld[i+1] <= 1'b0;
            end else if (rdy[i]) begin
                vld[i+1] <= vld[i];
            end
        end

        always_ff @(posedge aclk) begin
            if (rdy[i] && vld[i]) begin
                dat[i+1] <= dat[i];
            end
        end
    end

endmodule

//--- hdl/network_viu_top.sv
////////////////////////////////////////////////////////////////////////////
// Single clock domain, streams carry tdata and tlast only
// Output latency is N_STAGES cycles without back-pressure
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module network_viu_top import viu_pkg::*; #(
    parameter int unsigned N_STAGES = 2
) (
    input  logic      aclk,
    input  logic      aresetn,

    // Control
    input  route_id_t vlan_ctrl,
    input  route_id_t viu_tx_tdest,

    // Route strobes from the RDMA and TCP connection tables
    input  route_id_t rdma_tx_route_id,
    input  logic      rdma_tx_route_id_valid,
    input  route_id_t tcp_tx_route_id,
    input  logic      tcp_tx_route_id_valid,

    // Transmit from the stack
    input  net_data_t s_axis_tx_tdata,
    input  logic      s_axis_tx_tlast,
    input  logic      s_axis_tx_tvalid,
    output logic      s_axis_tx_tready,

    // Transmit toward the MAC
    output net_data_t m_axis_tx_tdata,
    output logic      m_axis_tx_tlast,
    output logic      m_axis_tx_tvalid,
    input  logic      m_axis_tx_tready,

    // Receive from the MAC
    input  net_data_t s_axis_rx_tdata,
    input  logic      s_axis_rx_tlast,
    input  logic      s_axis_rx_tvalid,
    output logic      s_axis_rx_tready,

    // Receive toward the stack, route beside every beat
    output net_data_t m_axis_rx_tdata,
    output logic      m_axis_rx_tlast,
    output logic      m_axis_rx_tvalid,
    output route_id_t viu_rx_tdest,
    input  logic      m_axis_rx_tready
);

    localparam int unsigned TX_W = NET_DATA_BITS + 1;
    localparam int unsigned RX_W = ROUTE_ID_BITS + NET_DATA_BITS + 1;

    route_id_t         tx_route;

    net_data_t         ins_tdata;
    logic              ins_tlast;
    logic              ins_tvalid;
    logic              ins_tready;

    net_data_t         ext_tdata;
    logic              ext_tlast;
    logic              ext_tvalid;
    logic              ext_tready;
    route_id_t         ext_route;

    logic [TX_W-1:0]   tx_slice_out;
    logic [RX_W-1:0]   rx_slice_out;

    route_id_select u_route_sel (
        .aclk                (aclk),
        .aresetn             (aresetn),
        .rdma_route_id       (rdma_tx_route_id),
        .rdma_route_id_valid (rdma_tx_route_id_valid),
        .tcp_route_id        (tcp_tx_route_id),
        .tcp_route_id_valid  (tcp_tx_route_id_valid),
        .ext_route_id        (viu_tx_tdest),
        .tx_route            (tx_route)
    );

    vlan_tag_insert u_tag_ins (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .tx_route (tx_route),
        .s_tdata  (s_axis_tx_tdata),
        .s_tlast  (s_axis_tx_tlast),
        .s_tvalid (s_axis_tx_tvalid),
        .s_tready (s_axis_tx_tready),
        .m_tdata  (ins_tdata),
        .m_tlast  (ins_tlast),
        .m_tvalid (ins_tvalid),
        .m_tready (ins_tready)
    );

    // Payload is {tlast, tdata}
    net_slice_array #(
        .N_STAGES (N_STAGES),
        .W        (TX_W)
    ) u_tx_slice (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .s_payload ({ins_tlast, ins_tdata}),
        .s_tvalid  (ins_tvalid),
        .s_tready  (ins_tready),
        .m_payload (tx_slice_out),
        .m_tvalid  (m_axis_tx_tvalid),
        .m_tready  (m_axis_tx_tready)
    );

    assign m_axis_tx_tlast = tx_slice_out[NET_DATA_BITS];
    assign m_axis_tx_tdata = tx_slice_out[NET_DATA_BITS-1:0];

    vlan_tag_extract u_tag_ext (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .vlan_ctrl (vlan_ctrl),
        .s_tdata   (s_axis_rx_tdata),
        .s_tlast   (s_axis_rx_tlast),
        .s_tvalid  (s_axis_rx_tvalid),
        .s_tready  (s_axis_rx_tready),
        .m_tdata   (ext_tdata),
        .m_tlast   (ext_tlast),
        .m_tvalid  (ext_tvalid),
        .m_tready  (ext_tready),
        .m_route   (ext_route)
    );

    // Payload is {route, tlast, tdata}
    net_slice_array #(
        .N_STAGES (N_STAGES),
        .W        (RX_W)
    ) u_rx_slice (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .s_payload ({ext_route, ext_tlast, ext_tdata}),
        .s_tvalid  (ext_tvalid),
        .s_tready  (ext_tready),
        .m_payload (rx_slice_out),
        .m_tvalid  (m_axis_rx_tvalid),
        .m_tready  (m_axis_rx_tready)
    );

    assign viu_rx_tdest    = rx_slice_out[RX_W-1 -: ROUTE_ID_BITS];
    assign m_axis_rx_tlast = rx_slice_out[NET_DATA_BITS];
    assign m_axis_rx_tdata = rx_slice_out[NET_DATA_BITS-1:0];

endmodule

//--- tb/tb_network_viu.sv
////////////////////////////////////////////////////////////////////////////
// Drives both stream sides of network_viu_top with N_STAGES of 2
// Route strobes are only given while the transmit side is idle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_network_viu import viu_pkg::*;;

    localparam int TIMEOUT = 2000;

    logic      aclk;
    logic      aresetn;
    route_id_t vlan_ctrl;
    route_id_t viu_tx_tdest;
    route_id_t rdma_tx_route_id;
    logic      rdma_tx_route_id_valid;
    route_id_t tcp_tx_route_id;
    logic      tcp_tx_route_id_valid;
    net_data_t s_axis_tx_tdata;
    logic      s_axis_tx_tlast;
    logic      s_axis_tx_tvalid;
    logic      s_axis_tx_tready;
    net_data_t m_axis_tx_tdata;
    logic      m_axis_tx_tlast;
    logic      m_axis_tx_tvalid;
    logic      m_axis_tx_tready;
    net_data_t s_axis_rx_tdata;
    logic      s_axis_rx_tlast;
    logic      s_axis_rx_tvalid;
    logic      s_axis_rx_tready;
    net_data_t m_axis_rx_tdata;
    logic      m_axis_rx_tlast;
    logic      m_axis_rx_tvalid;
    route_id_t viu_rx_tdest;
    logic      m_axis_rx_tready;

    integer    seed = 2;
    int        errors = 0;
    int        tests_run = 0;
    int        tests_bad = 0;
    int        errors_at_start;
    string     cur_test;
    bit        rand_ready;
    route_id_t held_rdma;
    route_id_t held_tcp;

    // Expected beats {tlast, tdata} and {route, tlast, tdata}
    logic [64:0] exp_tx[$];
    logic [64:0] got_tx[$];
    logic [78:0] exp_rx[$];
    logic [78:0] got_rx[$];

    network_viu_top #(.N_STAGES(2)) u_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // TPID 8100 in [63:48], route in [45:32], rest zero
    function automatic net_data_t expected_tag(input route_id_t r);
        net_data_t t;
        t = '0;
        t[63:48] = 16'h8100;
        t[45:32] = r;
        return t;
    endfunction

    function automatic route_id_t expected_route();
        if (held_rdma != 0) begin
            return held_rdma;
        end else if (held_tcp != 0) begin
            return held_tcp;
        end
        return viu_tx_tdest;
    endfunction

    // Receiver id sits at route bits [5:2], so tag bits [37:34]
    function automatic bit rx_accepts(input net_data_t tag, input route_id_t ctrl);
        return (tag[63:48] == 16'h8100) && (tag[37:34] == ctrl[5:2]);
    endfunction

    // Output monitor
    always @(posedge aclk) begin
        if (aresetn && m_axis_tx_tvalid && m_axis_tx_tready) begin
            got_tx.push_back({m_axis_tx_tlast, m_axis_tx_tdata});
        end
        if (aresetn && m_axis_rx_tvalid && m_axis_rx_tready) begin
            got_rx.push_back({viu_rx_tdest, m_axis_rx_tlast, m_axis_rx_tdata});
        end
    end

    always @(negedge aclk) begin : compare
        logic [64:0] gt;
        logic [64:0] et;
        logic [78:0] gr;
        logic [78:0] er;
        while (got_tx.size() > 0) begin
            gt = got_tx.pop_front();
            if (exp_tx.size() == 0) begin
                $display("unexpected beat %h on the transmit output in %s", gt, cur_test);
                errors++;
            end else begin
                et = exp_tx.pop_front();
                assert (gt == et) else begin
                    $display("[FAIL] %s tx expected %h actual %h", cur_test, et, gt);
                    errors++;
                end
            end
        end
        while (got_rx.size() > 0) begin
            gr = got_rx.pop_front();
            if (exp_rx.size() == 0) begin
                $display("unexpected beat %h on the receive output in %s", gr, cur_test);
                errors++;
            end else begin
                er = exp_rx.pop_front();
                assert (gr == er) else begin
                    $display("[FAIL] %s rx expected %h actual %h", cur_test, er, gr);
                    errors++;
                end
            end
        end
    end

    // Random back-pressure only while enabled
    always @(negedge aclk) begin
        m_axis_tx_tready = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
        m_axis_rx_tready = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
    end

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != errors_at_start) begin
            tests_bad++;
        end
        $display("test %s done, %0d errors", cur_test, errors - errors_at_start);
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while ((exp_tx.size() || exp_rx.size() || got_tx.size() || got_rx.size())
               && t < TIMEOUT) begin
            @(negedge aclk);
            t++;
        end
        if (t >= TIMEOUT) begin
            $display("timeout in %s, expected beats never arrived", cur_test);
            errors++;
            exp_tx.delete();
            exp_rx.delete();
        end
    endtask

    task automatic strobe_route(input bit is_rdma, input route_id_t id);
        @(negedge aclk);
        if (is_rdma) begin
            rdma_tx_route_id = id;
            rdma_tx_route_id_valid = 1'b1;
            held_rdma = id;
        end else begin
            tcp_tx_route_id = id;
            tcp_tx_route_id_valid = 1'b1;
            held_tcp = id;
        end
        @(negedge aclk);
        rdma_tx_route_id_valid = 1'b0;
        tcp_tx_route_id_valid = 1'b0;
    endtask

    task automatic send_tx(input int n_body, input bit gaps);
        net_data_t d;
        int        t;
        exp_tx.push_back({1'b0, expected_tag(expected_route())});
        for (int k = 0; k < n_body; k++) begin
            if (gaps) begin
                repeat ($random(seed) & 3) @(negedge aclk);
            end
            d = {$random(seed), $random(seed)};
            exp_tx.push_back({k == n_body - 1, d});
            s_axis_tx_tdata = d;
            s_axis_tx_tlast = (k == n_body - 1);
            s_axis_tx_tvalid = 1'b1;
            t = 0;
            do begin
                @(posedge aclk);
                t++;
            end while (!s_axis_tx_tready && t < TIMEOUT);
            if (t >= TIMEOUT) begin
                $display("timeout in %s, transmit input never became ready", cur_test);
                errors++;
            end
            @(negedge aclk);
            s_axis_tx_tvalid = 1'b0;
        end
    endtask

    task automatic send_rx(input net_data_t tag, input int n_body, input bit gaps);
        net_data_t d;
        bit        ok;
        int        t;
        ok = rx_accepts(tag, vlan_ctrl);
        for (int k = 0; k <= n_body; k++) begin
            if (gaps) begin
                repeat ($random(seed) & 3) @(negedge aclk);
            end
            // Beat 0 is the tag
            d = (k == 0) ? tag : {$random(seed), $random(seed)};
            if (ok && k > 0) begin
                exp_rx.push_back({tag[45:32], k == n_body, d});
            end
            s_axis_rx_tdata = d;
            s_axis_rx_tlast = (k == n_body);
            s_axis_rx_tvalid = 1'b1;
            t = 0;
            do begin
                @(posedge aclk);
                t++;
            end while (!s_axis_rx_tready && t < TIMEOUT);
            if (t >= TIMEOUT) begin
                $display("timeout in %s, receive input never became ready", cur_test);
                errors++;
            end
            @(negedge aclk);
            s_axis_rx_tvalid = 1'b0;
        end
    endtask

    function automatic net_data_t random_rx_tag();
        route_id_t r;
        net_data_t t;
        r = $random(seed);
        if (r[0]) begin
            r[5:2] = vlan_ctrl[5:2];
        end
        t = expected_tag(r);
        if (($random(seed) & 7) == 0) begin
            t[63:48] = 16'h88a8;
        end
        return t;
    endfunction

    initial begin
        aresetn = 1'b0;
        vlan_ctrl = 14'h014;
        viu_tx_tdest = 14'h0358;
        rdma_tx_route_id = '0;
        rdma_tx_route_id_valid = 1'b0;
        tcp_tx_route_id = '0;
        tcp_tx_route_id_valid = 1'b0;
        s_axis_tx_tdata = '0;
        s_axis_tx_tlast = 1'b0;
        s_axis_tx_tvalid = 1'b0;
        s_axis_rx_tdata = '0;
        s_axis_rx_tlast = 1'b0;
        s_axis_rx_tvalid = 1'b0;
        m_axis_tx_tready = 1'b1;
        m_axis_rx_tready = 1'b1;
        rand_ready = 1'b0;
        held_rdma = '0;
        held_tcp = '0;
        cur_test = "reset";
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        start_test("idle_after_reset");
        repeat (4) begin
            @(posedge aclk);
            assert (!m_axis_tx_tvalid && !m_axis_rx_tvalid) else begin
                $display("output valid raised with no input in %s", cur_test);
                errors++;
            end
        end
        @(negedge aclk);
        send_tx(3, 1'b0);
        wait_drained();
        finish_test();

        start_test("route_priority");
        strobe_route(1'b0, 14'h02a4);
        send_tx(2, 1'b0);
        wait_drained();
        strobe_route(1'b1, 14'h01c8);
        send_tx(2, 1'b0);
        wait_drained();
        strobe_route(1'b1, 14'h0000);
        send_tx(1, 1'b0);
        wait_drained();
        strobe_route(1'b0, 14'h0000);
        send_tx(2, 1'b0);
        wait_drained();
        finish_test();

        start_test("rx_accept");
        send_rx(expected_tag(14'h0294), 4, 1'b0);
        wait_drained();
        finish_test();

        start_test("rx_drop");
        send_rx(expected_tag(14'h0298), 3, 1'b0);
        send_rx({16'h88a8, 2'b00, 14'h0294, 32'h0}, 2, 1'b0);
        send_rx(expected_tag(14'h0054), 3, 1'b0);
        wait_drained();
        finish_test();

        start_test("random_traffic");
        rand_ready = 1'b1;
        fork
            for (int p = 0; p < 12; p++) begin
                send_tx(1 + (($random(seed) & 32'h7fff) % 6), 1'b1);
            end
            for (int p = 0; p < 12; p++) begin
                send_rx(random_rx_tag(), 1 + (($random(seed) & 32'h7fff) % 6), 1'b1);
            end
        join
        wait_drained();
        rand_ready = 1'b0;
        finish_test();

        $display("ran %0d tests, %0d with errors, %0d errors total",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
hdl/viu_pkg.sv
hdl/route_id_select.sv
hdl/vlan_tag_insert.sv
hdl/vlan_tag_extract.sv
hdl/net_slice_array.sv
hdl/network_viu_top.sv
tb/tb_network_viu.sv

//--- Bender.yml
package:
  name: network_viu

sources:
  - files:
      - hdl/viu_pkg.sv
      - hdl/route_id_select.sv
      - hdl/vlan_tag_insert.sv
      - hdl/vlan_tag_extract.sv
      - hdl/net_slice_array.sv
      - hdl/network_viu_top.sv
  - target: test
    files:
      - tb/tb_network_viu.sv
